//--- hw/contra_mem_pkg.sv
/*
  ROM layout in SDRAM, addresses in 16-bit words
  Regions sit back to back: main, sound, gfx1, gfx2
  Each region size follows its slot address width
  Anything at or past rom_end is not part of the image
*/
package contra_mem_pkg;

    localparam int sdram_aw = 22;  // SDRAM 16-bit word address

    // Main CPU ROM, byte addressed
    localparam int main_aw = 17;
    localparam int main_dw = 8;

    // Sound CPU ROM, byte addressed
    localparam int snd_aw = 15;
    localparam int snd_dw = 8;

    // Each graphics ROM, addressed in 16-bit halves
    localparam int gfx_aw = 18;
    localparam int gfx_dw = 16;

    // Region starts, byte sizes halved into word counts
    localparam logic [sdram_aw-1:0] snd_offset  = 22'h2_0000 >> 1;
    localparam logic [sdram_aw-1:0] gfx1_offset = snd_offset + (22'h0_8000 >> 1);
    localparam logic [sdram_aw-1:0] gfx2_offset = gfx1_offset + (22'h8_0000 >> 1);

    // First word past gfx2
    localparam logic [sdram_aw-1:0] rom_end = gfx2_offset + (22'h8_0000 >> 1);

endpackage

//--- hw/contra_sdram_pkg.sv
/*
  One 32-bit SDRAM read, two consecutive 16-bit words
  Half 0 and bytes 0..1 come from the even word address
  Byte 0 holds the even download byte
*/
package contra_sdram_pkg;

    localparam int sdram_dw = 32;  // Read data width
    localparam int half_w   = 16;
    localparam int byte_w   = 8;

    // Same read word, seen by 16-bit or 8-bit clients
    typedef union packed {
        logic [sdram_dw/half_w-1:0][half_w-1:0] half;
        logic [sdram_dw/byte_w-1:0][byte_w-1:0] bytes;
    } sdram_word_t;

endpackage

//--- hw/contra_cen.sv
/*
  Pixel clock enables from clk
  pxl2_cen is 1 in 4 cycles, pxl_cen 1 in 8, both registered
  First pxl2_cen comes 4 cycles after reset release
*/
`timescale 1ns/1ns

module contra_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            pxl2_cen <= cnt[1:0] == 2'd3;  // Every 4th
            pxl_cen  <= cnt == 3'd7;       // Every other pxl2_cen
        end
    end

endmodule

//--- hw/contra_prom_we.sv
/*
  Download bytes into SDRAM write requests
  One request is held until sdram_ack; the source waits for prog_we low
  Bytes at or beyond rom_end are dropped
  prog_mask is active low, even bytes go to the low lane
*/
`timescale 1ns/1ns

module contra_prom_we (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                downloading,
    input  logic [24:0]                         ioctl_addr,
    input  logic [7:0]                          ioctl_data,
    input  logic                                ioctl_wr,
    input  logic                                sdram_ack,
    output logic [contra_mem_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]                          prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_we
);

    import contra_mem_pkg::*;

    logic in_rom;
    logic take;

    // Word address compared against the end of the image
    assign in_rom = ioctl_addr[24:1] < 24'(rom_end);
    assign take   = downloading && ioctl_wr && in_rom;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (take) begin
            prog_we <= 1'b1;
        end else if (prog_we && sdram_ack) begin
            prog_we <= 1'b0;  // SDRAM took it
        end
    end

    // Payload captured with the request
    always_ff @(posedge clk) begin
        if (take) begin
            prog_addr <= ioctl_addr[sdram_aw:1];
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;  // Odd byte, high lane
        end
    end

endmodule

//--- hw/contra_rom_slot.sv
/*
  Cached ROM slot, keeps the last 32-bit word fetched
  Client holds cs and addr until ok; dw is 8 or 16 only
  ok comes 1 cycle after addr on a hit, 1 cycle after rd_done on a miss
  flush drops the cached word
*/
`timescale 1ns/1ns

module contra_rom_slot #(
    parameter int                                aw     = 17,
    parameter int                                dw     = 8,
    parameter logic [contra_mem_pkg::sdram_aw-1:0] offset = '0
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                flush,
    input  logic                                cs,
    input  logic [aw-1:0]                       addr,
    output logic [dw-1:0]                       data,
    output logic                                ok,
    output logic                                req,
    output logic [contra_mem_pkg::sdram_aw-1:0] req_addr,
    input  contra_sdram_pkg::sdram_word_t       rd_data,
    input  logic                                rd_done
);

    import contra_mem_pkg::*;
    import contra_sdram_pkg::*;

    localparam int sel_w = (dw == 8) ? 2 : 1;  // Address bits inside one word

    sdram_word_t         cache_q;
    sdram_word_t         fetch;
    logic [aw-sel_w-1:0] tag_q;
    logic                valid_q;
    logic                hit;
    logic [dw-1:0]       pick;

    assign hit      = valid_q && tag_q == addr[aw-1:sel_w];
    assign req      = cs && !hit;
    assign req_addr = offset + sdram_aw'({addr[aw-1:sel_w], 1'b0});  // Even word

    // New word bypasses the cache on its arrival cycle
    assign fetch = rd_done ? rd_data : cache_q;

    generate
        if (dw == 8) begin : g_byte
            assign pick = fetch.bytes[addr[1:0]];
        end else begin : g_half
            assign pick = fetch.half[addr[0]];
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ok      <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
            ok      <= 1'b0;
        end else begin
            if (rd_done)
                valid_q <= 1'b1;
            ok <= cs && (rd_done || hit);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_done) begin
            cache_q <= rd_data;
            tag_q   <= addr[aw-1:sel_w];  // Client keeps addr stable until ok
        end
        data <= pick;
    end

endmodule

//--- hw/contra_rom_arb.sv
/*
  Four ROM slots sharing one SDRAM read port
  Fixed priority: main, sound, gfx1, gfx2; one read in flight
  No new read starts while downloading, caches flushed meanwhile
  refresh_en is registered, high in vblank with no read pending
*/
`timescale 1ns/1ns

module contra_rom_arb (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                lvbl,
    input  logic                                downloading,
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    input  contra_sdram_pkg::sdram_word_t       data_read,
    input  logic                                main_cs,
    input  logic [contra_mem_pkg::main_aw-1:0]  main_addr,
    output logic [contra_mem_pkg::main_dw-1:0]  main_data,
    output logic                                main_ok,
    input  logic                                snd_cs,
    input  logic [contra_mem_pkg::snd_aw-1:0]   snd_addr,
    output logic [contra_mem_pkg::snd_dw-1:0]   snd_data,
    output logic                                snd_ok,
    input  logic                                gfx1_cs,
    input  logic [contra_mem_pkg::gfx_aw-1:0]   gfx1_addr,
    output logic [contra_mem_pkg::gfx_dw-1:0]   gfx1_data,
    output logic                                gfx1_ok,
    input  logic                                gfx2_cs,
    input  logic [contra_mem_pkg::gfx_aw-1:0]   gfx2_addr,
    output logic [contra_mem_pkg::gfx_dw-1:0]   gfx2_data,
    output logic                                gfx2_ok,
    output logic                                sdram_req,
    output logic [contra_mem_pkg::sdram_aw-1:0] sdram_addr,
    output logic                                refresh_en
);

    import contra_mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_ack,   // sdram_req held
        st_data   // Waiting for data_rdy
    } arb_state_t;

    arb_state_t          state_q;
    arb_state_t          state_nxt;
    logic [3:0]          req;        // 0 main, 1 sound, 2 gfx1, 3 gfx2
    logic [sdram_aw-1:0] req_addr [4];
    logic [3:0]          rd_done;
    logic [1:0]          win;
    logic [1:0]          sel_q;      // Slot being served
    logic                any_req;

    contra_rom_slot #(.aw(main_aw), .dw(main_dw), .offset('0)) u_main (
        .clk(clk), .rst_n(rst_n), .flush(downloading),
        .cs(main_cs), .addr(main_addr), .data(main_data), .ok(main_ok),
        .req(req[0]), .req_addr(req_addr[0]),
        .rd_data(data_read), .rd_done(rd_done[0])
    );

    contra_rom_slot #(.aw(snd_aw), .dw(snd_dw), .offset(snd_offset)) u_snd (
        .clk(clk), .rst_n(rst_n), .flush(downloading),
        .cs(snd_cs), .addr(snd_addr), .data(snd_data), .ok(snd_ok),
        .req(req[1]), .req_addr(req_addr[1]),
        .rd_data(data_read), .rd_done(rd_done[1])
    );

    contra_rom_slot #(.aw(gfx_aw), .dw(gfx_dw), .offset(gfx1_offset)) u_gfx1 (
        .clk(clk), .rst_n(rst_n), .flush(downloading),
        .cs(gfx1_cs), .addr(gfx1_addr), .data(gfx1_data), .ok(gfx1_ok),
        .req(req[2]), .req_addr(req_addr[2]),
        .rd_data(data_read), .rd_done(rd_done[2])
    );

    contra_rom_slot #(.aw(gfx_aw), .dw(gfx_dw), .offset(gfx2_offset)) u_gfx2 (
        .clk(clk), .rst_n(rst_n), .flush(downloading),
        .cs(gfx2_cs), .addr(gfx2_addr), .data(gfx2_data), .ok(gfx2_ok),
        .req(req[3]), .req_addr(req_addr[3]),
        .rd_data(data_read), .rd_done(rd_done[3])
    );

    // Lowest index wins
    always_comb begin
        win     = 2'd0;
        any_req = 1'b0;
        for (int i = 3; i >= 0; i--) begin
            if (req[i]) begin
                win     = 2'(i);
                any_req = 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state_q;
        case (state_q)
            st_idle: if (!downloading && any_req) state_nxt = st_ack;
            st_ack:  if (sdram_ack) state_nxt = st_data;
            st_data: if (data_rdy) state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
    end

    // Only the granted slot sees data_rdy
    always_comb begin
        for (int i = 0; i < 4; i++)
            rd_done[i] = data_rdy && state_q == st_data && sel_q == 2'(i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            sel_q      <= 2'd0;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b0;
        end else begin
            state_q    <= state_nxt;
            sdram_req  <= state_nxt == st_ack;  // Held until ack
            refresh_en <= !lvbl && state_nxt == st_idle;
            if (state_q == st_idle && state_nxt == st_ack)
                sel_q <= win;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && state_nxt == st_ack)
            sdram_addr <= req_addr[win];
    end

endmodule

//--- hw/contra_game.sv
/*
  Memory side of the game core on a single clock
  Slot clients are top-level ports; sdram_ack is shared by
  download writes and ROM reads, which never overlap
*/
`timescale 1ns/1ns

module contra_game (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                lvbl,
    input  logic                                downloading,
    // Download
    input  logic [24:0]                         ioctl_addr,
    input  logic [7:0]                          ioctl_data,
    input  logic                                ioctl_wr,
    // SDRAM
    input  logic                                sdram_ack,
    input  logic                                data_rdy,
    input  contra_sdram_pkg::sdram_word_t       data_read,
    // ROM clients
    input  logic                                main_cs,
    input  logic [contra_mem_pkg::main_aw-1:0]  main_addr,
    output logic [contra_mem_pkg::main_dw-1:0]  main_data,
    output logic                                main_ok,
    input  logic                                snd_cs,
    input  logic [contra_mem_pkg::snd_aw-1:0]   snd_addr,
    output logic [contra_mem_pkg::snd_dw-1:0]   snd_data,
    output logic                                snd_ok,
    input  logic                                gfx1_cs,
    input  logic [contra_mem_pkg::gfx_aw-1:0]   gfx1_addr,
    output logic [contra_mem_pkg::gfx_dw-1:0]   gfx1_data,
    output logic                                gfx1_ok,
    input  logic                                gfx2_cs,
    input  logic [contra_mem_pkg::gfx_aw-1:0]   gfx2_addr,
    output logic [contra_mem_pkg::gfx_dw-1:0]   gfx2_data,
    output logic                                gfx2_ok,
    // Outputs
    output logic                                pxl2_cen,  // 12 MHz
    output logic                                pxl_cen,   // 6 MHz
    output logic [contra_mem_pkg::sdram_aw-1:0] prog_addr,
    output logic [7:0]                          prog_data,
    output logic [1:0]                          prog_mask, // Active low
    output logic                                prog_we,
    output logic                                sdram_req,
    output logic [contra_mem_pkg::sdram_aw-1:0] sdram_addr,
    output logic                                refresh_en
);

    contra_cen u_cen (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .pxl2_cen   ( pxl2_cen    ),
        .pxl_cen    ( pxl_cen     )
    );

    contra_prom_we u_prom (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .downloading( downloading ),
        .ioctl_addr ( ioctl_addr  ),
        .ioctl_data ( ioctl_data  ),
        .ioctl_wr   ( ioctl_wr    ),
        .sdram_ack  ( sdram_ack   ),
        .prog_addr  ( prog_addr   ),
        .prog_data  ( prog_data   ),
        .prog_mask  ( prog_mask   ),
        .prog_we    ( prog_we     )
    );

    contra_rom_arb u_rom (
        .clk        ( clk         ),
        .rst_n      ( rst_n       ),
        .lvbl       ( lvbl        ),
        .downloading( downloading ),
        .sdram_ack  ( sdram_ack   ),
        .data_rdy   ( data_rdy    ),
        .data_read  ( data_read   ),
        .main_cs    ( main_cs     ),
        .main_addr  ( main_addr   ),
        .main_data  ( main_data   ),
        .main_ok    ( main_ok     ),
        .snd_cs     ( snd_cs      ),
        .snd_addr   ( snd_addr    ),
        .snd_data   ( snd_data    ),
        .snd_ok     ( snd_ok      ),
        .gfx1_cs    ( gfx1_cs     ),
        .gfx1_addr  ( gfx1_addr   ),
        .gfx1_data  ( gfx1_data   ),
        .gfx1_ok    ( gfx1_ok     ),
        .gfx2_cs    ( gfx2_cs     ),
        .gfx2_addr  ( gfx2_addr   ),
        .gfx2_data  ( gfx2_data   ),
        .gfx2_ok    ( gfx2_ok     ),
        .sdram_req  ( sdram_req   ),
        .sdram_addr ( sdram_addr  ),
        .refresh_en ( refresh_en  )
    );

endmodule

//--- bench/sdram_model.sv
/*
  Behavioural SDRAM for the testbench, sparse word storage
  Serves one request at a time, prog_we write or sdram_req read
  Ack after 1 to 4 cycles; read data 1 to 3 cycles after the ack
  Unwritten words read as zero
*/
`timescale 1ns/1ns

module sdram_model (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                prog_we,
    input  logic [contra_mem_pkg::sdram_aw-1:0] prog_addr,
    input  logic [7:0]                          prog_data,
    input  logic [1:0]                          prog_mask,
    input  logic                                sdram_req,
    input  logic [contra_mem_pkg::sdram_aw-1:0] sdram_addr,
    output logic                                sdram_ack,
    output logic                                data_rdy,
    output contra_sdram_pkg::sdram_word_t       data_read
);

    logic [15:0] mem [int];  // 16-bit words by word address

    function automatic logic [15:0] read_word(input int a);
        if (mem.exists(a))
            return mem[a];
        return 16'h0000;
    endfunction

    initial begin
        int   addr;
        logic is_wr;
        logic [15:0] w;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && (prog_we || sdram_req)) begin
                is_wr = prog_we;
                addr  = is_wr ? int'(prog_addr) : int'(sdram_addr);
                repeat ($urandom_range(3)) begin
                    @(posedge clk);
                    #1;
                end
                sdram_ack = 1'b1;
                if (is_wr) begin
                    w = read_word(addr);
                    if (!prog_mask[0]) w[7:0] = prog_data;   // Low lane
                    if (!prog_mask[1]) w[15:8] = prog_data;  // High lane
                    mem[addr] = w;
                end
                @(posedge clk);
                #1;
                sdram_ack = 1'b0;
                if (!is_wr) begin
                    repeat ($urandom_range(2)) begin
                        @(posedge clk);
                        #1;
                    end
                    data_rdy  = 1'b1;
                    data_read = {read_word(addr + 1), read_word(addr)};  // Even word in half 0
                    @(posedge clk);
                    #1;
                    data_rdy = 1'b0;
                end
            end
        end
    end

endmodule

//--- bench/contra_game_tb.sv
/*
  Testbench for contra_game with a sparse SDRAM model
  Random download in 32-bit blocks, then random cached reads
  Expected data comes from a byte image kept here
*/
`timescale 1ns/1ns

module contra_game_tb;

    import contra_mem_pkg::*;
    import contra_sdram_pkg::*;

    localparam int n_blocks  = 40;
    localparam int n_beyond  = 8;
    localparam int n_rand    = 24;
    localparam int dl_len    = n_blocks * 4 + n_beyond + 4;
    localparam int rd_count  = 4 + n_rand * 2 + 3;
    localparam int limit     = dl_len * 8 + rd_count * 20 + 200;
    localparam int snd_base  = 2 * int'(snd_offset);   // Byte addresses in download space
    localparam int gfx1_base = 2 * int'(gfx1_offset);
    localparam int gfx2_base = 2 * int'(gfx2_offset);
    localparam int end_base  = 2 * int'(rom_end);

    logic clk = 1'b0;
    logic rst_n, lvbl, downloading, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic sdram_ack, data_rdy;
    sdram_word_t data_read;
    logic main_cs, snd_cs, gfx1_cs, gfx2_cs;
    logic [main_aw-1:0] main_addr;
    logic [main_dw-1:0] main_data;
    logic [snd_aw-1:0]  snd_addr;
    logic [snd_dw-1:0]  snd_data;
    logic [gfx_aw-1:0]  gfx1_addr, gfx2_addr;
    logic [gfx_dw-1:0]  gfx1_data, gfx2_data;
    logic main_ok, snd_ok, gfx1_ok, gfx2_ok;
    logic pxl2_cen, pxl_cen, prog_we, sdram_req, refresh_en;
    logic [sdram_aw-1:0] prog_addr, sdram_addr;
    logic [7:0] prog_data;
    logic [1:0] prog_mask;

    logic [7:0] image [int];   // Downloaded bytes by download address
    int blocks [4][$];         // Block starts per slot, in slot addresses
    int mismatches = 0;
    int failures = 0;
    int cycles = 0;
    int edges = 0;
    int refresh_seen = 0;
    logic outstanding = 1'b0;
    logic lvbl_prev = 1'b1;

    contra_game contra_game_inst (.*);

    sdram_model sdram_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        #1 lvbl = ($urandom % 4) != 0;  // Vertical blank about a quarter of the time
    end

    always @(posedge clk) begin
        cycles++;
        if (rst_n)
            edges++;
        if (cycles > limit) begin
            $display("Error: run did not finish within %0d cycles", limit);
            $display("Test failed");
            $finish;
        end
    end

    // Enables, refresh and download monitors, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag("pxl2_cen", edges > 0 && edges % 4 == 0, pxl2_cen);
            check_flag("pxl_cen", edges > 0 && edges % 8 == 0, pxl_cen);
            if (edges > 0)
                check_flag("refresh_en", !lvbl_prev && !sdram_req && !outstanding, refresh_en);
            if (refresh_en)
                refresh_seen++;
            if (sdram_req)
                outstanding = 1'b1;
            if (data_rdy)
                outstanding = 1'b0;
            if (downloading && sdram_req) begin
                failures++;
                $display("Error: sdram_req raised while downloading");
            end
        end
        lvbl_prev = lvbl;
    end

    task automatic check_prog(input string name, input logic [sdram_aw-1:0] exp_addr,
                              input logic [sdram_aw-1:0] act_addr, input logic [7:0] exp_data,
                              input logic [7:0] act_data, input logic [1:0] exp_mask,
                              input logic [1:0] act_mask);
        if (exp_addr !== act_addr || exp_data !== act_data || exp_mask !== act_mask) begin
            mismatches++;
            $display("Mismatch %s: expected %h/%h/%b, actual %h/%h/%b", name,
                     exp_addr, exp_data, exp_mask, act_addr, act_data, act_mask);
        end
    endtask

    task automatic check_addr(input string name, input logic [sdram_aw-1:0] exp_v,
                              input logic [sdram_aw-1:0] act_v);
        if (exp_v !== act_v) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            mismatches++;
            $display("Mismatch %s: expected %b, actual %b", name, exp_v, act_v);
        end
    endtask

    task automatic check_byte(input string name, input logic [main_dw-1:0] exp_v,
                              input logic [main_dw-1:0] act_v);
        if (exp_v !== act_v) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_half(input string name, input logic [gfx_dw-1:0] exp_v,
                              input logic [gfx_dw-1:0] act_v);
        if (exp_v !== act_v) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    function automatic logic [7:0] img(input int ba);
        return image.exists(ba) ? image[ba] : 8'hxx;
    endfunction

    function automatic int slot_base(input int s);
        case (s)
            0: return 0;
            1: return snd_base;
            2: return gfx1_base;
            default: return gfx2_base;
        endcase
    endfunction

    // Download address of the first byte behind slot address a
    function automatic int byte_of(input int s, input int a);
        return s < 2 ? slot_base(s) + a : slot_base(s) + 2 * a;
    endfunction

    // Even SDRAM word holding the 32-bit word of slot address a
    function automatic logic [sdram_aw-1:0] word_of(input int s, input int a);
        return s < 2 ? slot_base(s) / 2 + (a / 4) * 2 : slot_base(s) / 2 + (a / 2) * 2;
    endfunction

    function automatic logic slot_ok(input int s);
        case (s)
            0: return main_ok;
            1: return snd_ok;
            2: return gfx1_ok;
            default: return gfx2_ok;
        endcase
    endfunction

    task automatic set_slot(input int s, input int a, input logic cs);
        case (s)
            0: begin main_cs = cs; main_addr = a; end
            1: begin snd_cs = cs; snd_addr = a; end
            2: begin gfx1_cs = cs; gfx1_addr = a; end
            default: begin gfx2_cs = cs; gfx2_addr = a; end
        endcase
    endtask

    task automatic compare_slot(input string name, input int s, input int a);
        int b;
        b = byte_of(s, a);
        case (s)
            0: check_byte(name, img(b), main_data);
            1: check_byte(name, img(b), snd_data);
            2: check_half(name, {img(b + 1), img(b)}, gfx1_data);
            default: check_half(name, {img(b + 1), img(b)}, gfx2_data);
        endcase
    endtask

    task automatic send_byte(input int ba, input logic [7:0] d);
        @(posedge clk);
        #1;
        ioctl_addr = ba;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        if (ba < end_base) begin
            image[ba] = d;
            if (!prog_we) begin
                failures++;
                $display("Error: prog_we did not rise for download byte %h", ba);
            end else begin
                check_prog("download", ba / 2, prog_addr, d, prog_data,
                           ba % 2 ? 2'b01 : 2'b10, prog_mask);
            end
            while (prog_we) begin
                @(posedge clk);
                #1;
            end
        end else begin
            repeat (2) begin
                if (prog_we) begin
                    failures++;
                    $display("Error: prog_we raised for byte %h beyond the ROM", ba);
                end
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic read_slot(input string name, input int s, input int a, output int lat);
        lat = 0;
        @(posedge clk);
        #1;
        set_slot(s, a, 1'b1);
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!slot_ok(s) && lat < 100);
        if (!slot_ok(s)) begin
            failures++;
            $display("Error: slot %0d never gave ok for address %h", s, a);
        end else begin
            compare_slot(name, s, a);
        end
    endtask

    initial begin
        int s, a, lat, n_req, got;
        int pick [4];
        logic prev_req;
        logic [sdram_aw-1:0] seen [4];
        void'($urandom(32'h136c));
        rst_n = 1'b0;
        lvbl = 1'b1;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        for (int i = 0; i < 4; i++)
            set_slot(i, 0, 1'b0);
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        // Download whole 32-bit words so every read has a full image behind it
        downloading = 1'b1;
        for (int i = 0; i < n_blocks; i++) begin
            s = $urandom % 4;
            a = s == 0 ? ($urandom % (1 << main_aw)) & ~3 :
                s == 1 ? ($urandom % (1 << snd_aw)) & ~3 :
                         ($urandom % (1 << gfx_aw)) & ~1;
            blocks[s].push_back(a);
            for (int k = 0; k < 4; k++)
                send_byte(byte_of(s, a) + k, $urandom);
        end
        for (int i = 0; i < n_beyond; i++)
            send_byte(end_base + ($urandom % 'h1_0000), $urandom);
        for (int i = 0; i < 4; i++)
            if (blocks[i].size() == 0) begin
                blocks[i].push_back(0);
                for (int k = 0; k < 4; k++)
                    send_byte(byte_of(i, 0) + k, $urandom);
            end
        @(posedge clk);
        #1 downloading = 1'b0;

        // All four slots at once, caches are empty after the download
        for (int i = 0; i < 4; i++) begin
            pick[i] = blocks[i][$urandom % blocks[i].size()] + $urandom % (i < 2 ? 4 : 2);
            set_slot(i, pick[i], 1'b1);
        end
        n_req = 0;
        got = 0;
        prev_req = 1'b0;
        for (int c = 0; c < 200 && got != 4'hf; c++) begin
            @(posedge clk);
            #1;
            if (sdram_req && !prev_req) begin
                if (n_req < 4)
                    seen[n_req] = sdram_addr;
                n_req++;
            end
            prev_req = sdram_req;
            for (int i = 0; i < 4; i++)
                if (!got[i] && slot_ok(i)) begin
                    got[i] = 1'b1;
                    compare_slot("concurrent read", i, pick[i]);
                end
        end
        if (got != 4'hf || n_req != 4) begin
            failures++;
            $display("Error: concurrent reads gave %0d requests and ok mask %b", n_req, got);
        end else begin
            for (int i = 0; i < 4; i++)
                check_addr("grant order", word_of(i, pick[i]), seen[i]);
        end

        // Random reads, each followed by a hit in the same 32-bit word
        for (int i = 0; i < n_rand; i++) begin
            s = $urandom % 4;
            a = blocks[s][$urandom % blocks[s].size()] + $urandom % (s < 2 ? 4 : 2);
            read_slot("random read", s, a, lat);
            a = s < 2 ? a ^ (1 + $urandom % 3) : a ^ 1;
            read_slot("same word read", s, a, lat);
            if (lat != 1 || sdram_req) begin
                failures++;
                $display("Error: same word read on slot %0d took %0d cycles or hit SDRAM", s, lat);
            end
        end

        // A new download must replace what the main slot has cached
        a = blocks[0][0];
        read_slot("before reload", 0, a, lat);
        for (int i = 0; i < 4; i++)
            set_slot(i, 0, 1'b0);
        @(posedge clk);
        #1 downloading = 1'b1;
        set_slot(1, blocks[1][0], 1'b1);  // Flushed slot asks, its read has to wait
        for (int k = 0; k < 4; k++)
            send_byte(a + k, img(a + k) ^ (8'd1 + 8'($urandom % 255)));
        @(posedge clk);
        #1 downloading = 1'b0;
        read_slot("after reload", 0, a, lat);

        if (refresh_seen == 0) begin
            failures++;
            $display("Error: refresh_en never went high");
        end
        repeat (2) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- project.f
hw/contra_mem_pkg.sv
hw/contra_sdram_pkg.sv
hw/contra_cen.sv
hw/contra_prom_we.sv
hw/contra_rom_slot.sv
hw/contra_rom_arb.sv
hw/contra_game.sv
bench/sdram_model.sv
bench/contra_game_tb.sv
